// ==== Makefile ====
# Verilator flow for the datapath testbench
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= dataPathTb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the testbench reads its stimulus relative to the project root
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed (exit status $$status)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
rtl/datapathPkg.sv
rtl/busMux.sv
rtl/registerFile.sv
rtl/mdrUnit.sv
rtl/aluUnit.sv
rtl/specialRegs.sv
rtl/dataPath.sv
test/dataPathTb.sv

// ==== rtl/aluUnit.sv ====
// Multi-cycle ALU
`default_nettype none

module aluUnit import datapathPkg::*; (
    input  logic               Clock,
    input  logic               rstN,
    input  logic [opWidth-1:0] opSelect,
    input  logic [31:0]        operandA,
    input  logic [31:0]        operandB,
    input  logic               start,
    output logic               finished,
    output zWord               aluResult
);

    localparam logic [1:0] stIdle = 2'd0;
    localparam logic [1:0] stBusy = 2'd1;
    localparam logic [1:0] stDone = 2'd2;

    logic [1:0]         state;
    logic [opWidth-1:0] opReg;
    logic [5:0]         stepCount;
    logic [31:0]        aReg;
    logic [31:0]        bReg;
    logic [31:0]        accHi;      // product high word or partial remainder
    logic [31:0]        accLo;      // multiplier bits or quotient bits
    logic [32:0]        mulNext;
    logic [32:0]        divShift;
    logic [32:0]        divTrial;
    logic               serialOp;
    zWord               resultReg;

    function automatic logic [31:0] simpleResult(input logic [opWidth-1:0] op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [63:0] rotl;
        logic [63:0] rotr;
        begin
            rotl = {a, a} << b[4:0];
            rotr = {a, a} >> b[4:0];
            case (op)
                opAdd:   simpleResult = a + b;
                opSub:   simpleResult = a - b;
                opAnd:   simpleResult = a & b;
                opOr:    simpleResult = a | b;
                opShl:   simpleResult = a << b[4:0];
                opShr:   simpleResult = a >> b[4:0];
                opRotl:  simpleResult = rotl[63:32];
                opRotr:  simpleResult = rotr[31:0];
                opNeg:   simpleResult = -b;     // unary ops take the bus operand
                opNot:   simpleResult = ~b;
                default: simpleResult = '0;
            endcase
        end
    endfunction

    assign serialOp = (opReg == opMul) || (opReg == opDiv);

    // shift-and-add step, unsigned
    assign mulNext = accLo[0] ? ({1'b0, accHi} + {1'b0, aReg}) : {1'b0, accHi};

    // restoring divide step; a zero divisor never borrows,
    // so the quotient fills with ones and the dividend ends up as remainder
    assign divShift = {accHi, accLo[31]};
    assign divTrial = divShift - {1'b0, bReg};

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state     <= stIdle;
            finished  <= 1'b0;
            opReg     <= '0;
            stepCount <= '0;
        end else begin
            case (state)
                stIdle: if (start) begin
                    opReg     <= opSelect;
                    stepCount <= '0;
                    state     <= stBusy;
                end
                stBusy: if (!serialOp || stepCount == 6'd32) begin
                    state    <= stDone;
                    finished <= 1'b1;
                end else begin
                    stepCount <= stepCount + 6'd1;
                end
                stDone: if (!start) begin   // finished drops once start is released
                    state    <= stIdle;
                    finished <= 1'b0;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == stIdle && start) begin
            aReg  <= operandA;
            bReg  <= operandB;
            accHi <= '0;
            accLo <= (opSelect == opDiv) ? operandA : operandB;
        end else if (state == stBusy) begin
            if (!serialOp) begin
                resultReg.product <= {32'd0, simpleResult(opReg, aReg, bReg)};
            end else if (stepCount == 6'd32) begin
                if (opReg == opMul) begin
                    resultReg.product <= {accHi, accLo};
                end else begin
                    resultReg.divPair.remainder <= accHi;
                    resultReg.divPair.quotient  <= accLo;
                end
            end else if (opReg == opMul) begin
                accHi <= mulNext[32:1];
                accLo <= {mulNext[0], accLo[31:1]};
            end else if (divTrial[32]) begin
                accHi <= divShift[31:0];            // restore
                accLo <= {accLo[30:0], 1'b0};
            end else begin
                accHi <= divTrial[31:0];
                accLo <= {accLo[30:0], 1'b1};
            end
        end
    end

    assign aluResult = resultReg;

    // four-phase handshake, a new start only after finished has dropped
    startAfterRelease: assert property (
        @(posedge Clock) disable iff (!rstN)
        $rose(start) |-> !finished
    ) else $error("aluUnit: start raised while finished still high");

    opStableWhileBusy: assert property (
        @(posedge Clock) disable iff (!rstN)
        (state == stBusy) |-> $stable(opSelect)
    ) else $error("aluUnit: opSelect changed during an operation");

endmodule

`default_nettype wire

// ==== rtl/busMux.sv ====
// Internal bus source mux
`default_nettype none

module busMux #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0]   rfData,
    input  logic [dataWidth-1:0]   pcData,
    input  logic [dataWidth-1:0]   irData,
    input  logic [dataWidth-1:0]   yData,
    input  logic [2*dataWidth-1:0] zData,
    input  logic [dataWidth-1:0]   marData,
    input  logic [dataWidth-1:0]   hiData,
    input  logic [dataWidth-1:0]   loData,
    input  logic [dataWidth-1:0]   mdrData,
    input  logic                   rfOut,
    input  logic                   pcOut,
    input  logic                   irOut,
    input  logic                   yOut,
    input  logic                   zLoOut,
    input  logic                   zHiOut,
    input  logic                   marOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   mdrOut,
    output logic [dataWidth-1:0]   bus
);

    logic [9:0] selVec;

    assign selVec = {rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut};

    // and-or mux, reads zero with nothing selected
    assign bus = ({dataWidth{rfOut}}  & rfData)
               | ({dataWidth{pcOut}}  & pcData)
               | ({dataWidth{irOut}}  & irData)
               | ({dataWidth{yOut}}   & yData)
               | ({dataWidth{zLoOut}} & zData[dataWidth-1:0])
               | ({dataWidth{zHiOut}} & zData[2*dataWidth-1:dataWidth])
               | ({dataWidth{marOut}} & marData)
               | ({dataWidth{hiOut}}  & hiData)
               | ({dataWidth{loOut}}  & loData)
               | ({dataWidth{mdrOut}} & mdrData);

    // the controller must never open two sources at once
    singleDriver: assert property (@(selVec) $onehot0(selVec))
        else $error("busMux: more than one source drives the bus");

endmodule

`default_nettype wire

// ==== rtl/dataPath.sv ====
// Single-bus datapath top
`default_nettype none

module dataPath import datapathPkg::*; #(
    parameter int dataWidth = 32,
    parameter int regCount = 16
) (
    input  logic                     Clock,
    input  logic                     rstN,
    // bus sources
    input  logic                     rfOut,
    input  logic                     pcOut,
    input  logic                     irOut,
    input  logic                     yOut,
    input  logic                     zLoOut,
    input  logic                     zHiOut,
    input  logic                     marOut,
    input  logic                     hiOut,
    input  logic                     loOut,
    input  logic                     mdrOut,
    // register loads
    input  logic                     rfIn,
    input  logic                     pcIn,
    input  logic                     incPc,
    input  logic                     irIn,
    input  logic                     yIn,
    input  logic                     zIn,
    input  logic                     marIn,
    input  logic                     hiIn,
    input  logic                     loIn,
    input  logic                     mdrIn,
    input  logic [regIndexWidth-1:0] rfSelect,
    input  logic [opWidth-1:0]       opSelect,
    input  logic                     start,
    input  logic                     read,
    input  logic [dataWidth-1:0]     memDataIn,
    output logic                     finished,
    output logic [dataWidth-1:0]     busValue   // the internal bus itself
);

    logic [dataWidth-1:0] rfData;
    logic [dataWidth-1:0] pcData;
    logic [dataWidth-1:0] irData;
    logic [dataWidth-1:0] yData;
    logic [dataWidth-1:0] marData;
    logic [dataWidth-1:0] hiData;
    logic [dataWidth-1:0] loData;
    logic [dataWidth-1:0] mdrData;
    zWord                 zData;
    zWord                 aluResult;

    busMux #(.dataWidth(dataWidth)) busMux0 (
        .rfData(rfData), .pcData(pcData), .irData(irData), .yData(yData),
        .zData(zData), .marData(marData), .hiData(hiData), .loData(loData),
        .mdrData(mdrData),
        .rfOut(rfOut), .pcOut(pcOut), .irOut(irOut), .yOut(yOut),
        .zLoOut(zLoOut), .zHiOut(zHiOut), .marOut(marOut), .hiOut(hiOut),
        .loOut(loOut), .mdrOut(mdrOut),
        .bus(busValue)
    );

    registerFile #(.dataWidth(dataWidth), .regCount(regCount)) registerFile0 (
        .Clock(Clock), .rstN(rstN), .rfIn(rfIn), .rfSelect(rfSelect),
        .bus(busValue), .rfData(rfData)
    );

    mdrUnit #(.dataWidth(dataWidth)) mdrUnit0 (
        .Clock(Clock), .rstN(rstN), .read(read), .mdrIn(mdrIn),
        .memDataIn(memDataIn), .bus(busValue), .mdrData(mdrData)
    );

    // Y is the A operand, the bus is B
    aluUnit aluUnit0 (
        .Clock(Clock), .rstN(rstN), .opSelect(opSelect),
        .operandA(yData), .operandB(busValue),
        .start(start), .finished(finished), .aluResult(aluResult)
    );

    specialRegs #(.dataWidth(dataWidth)) specialRegs0 (
        .Clock(Clock), .rstN(rstN), .bus(busValue), .aluResult(aluResult),
        .pcIn(pcIn), .incPc(incPc), .irIn(irIn), .yIn(yIn), .zIn(zIn),
        .finished(finished), .marIn(marIn), .hiIn(hiIn), .loIn(loIn),
        .pcData(pcData), .irData(irData), .yData(yData), .zData(zData),
        .marData(marData), .hiData(hiData), .loData(loData)
    );

endmodule

`default_nettype wire

// ==== rtl/datapathPkg.sv ====
// Datapath shared definitions
`default_nettype none

package datapathPkg;

    // register file index width, matches sixteen registers
    localparam int regIndexWidth = 4;
    localparam int opWidth = 5;          // width of opSelect

    // ALU operation codes
    localparam logic [opWidth-1:0] opAdd  = 5'd0;
    localparam logic [opWidth-1:0] opSub  = 5'd1;
    localparam logic [opWidth-1:0] opAnd  = 5'd2;
    localparam logic [opWidth-1:0] opOr   = 5'd3;
    localparam logic [opWidth-1:0] opShl  = 5'd4;
    localparam logic [opWidth-1:0] opShr  = 5'd5;   // logical
    localparam logic [opWidth-1:0] opRotl = 5'd6;
    localparam logic [opWidth-1:0] opRotr = 5'd7;
    localparam logic [opWidth-1:0] opNeg  = 5'd8;
    localparam logic [opWidth-1:0] opNot  = 5'd9;

    // serial ops, 32 iterations each
    localparam logic [opWidth-1:0] opMul  = 5'd10;
    localparam logic [opWidth-1:0] opDiv  = 5'd11;

    // divide result, remainder lands in HI and quotient in LO
    typedef struct packed {
        logic [31:0] remainder;     // upper word
        logic [31:0] quotient;      // lower word
    } divPairT;

    // the Z word, one 64-bit register read two ways
    typedef union packed {
        logic [63:0] product;
        divPairT     divPair;
    } zWord;

endpackage

`default_nettype wire

// ==== rtl/mdrUnit.sv ====
// Memory data register
`default_nettype none

module mdrUnit #(
    parameter int dataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 read,
    input  logic                 mdrIn,
    input  logic [dataWidth-1:0] memDataIn,
    input  logic [dataWidth-1:0] bus,
    output logic [dataWidth-1:0] mdrData
);

    logic [dataWidth-1:0] mdrNext;

    // memory read wins, otherwise the MDR is written from the bus
    assign mdrNext = read ? memDataIn : bus;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrData <= '0;
        end else if (mdrIn) begin
            mdrData <= mdrNext;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
// General register file
`default_nettype none

module registerFile import datapathPkg::*; #(
    parameter int dataWidth = 32,
    parameter int regCount = 16
) (
    input  logic                     Clock,
    input  logic                     rstN,
    input  logic                     rfIn,
    input  logic [regIndexWidth-1:0] rfSelect,
    input  logic [dataWidth-1:0]     bus,
    output logic [dataWidth-1:0]     rfData
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rfIn) begin
            regs[rfSelect] <= bus;      // write from the bus
        end
    end

    // asynchronous read port onto the bus mux
    assign rfData = regs[rfSelect];

    // a write must address an existing register
    selectInRange: assert property (
        @(posedge Clock) disable iff (!rstN)
        rfIn |-> (!$isunknown(rfSelect) && int'(rfSelect) < regCount)
    ) else $error("registerFile: write to register %0d outside the file", rfSelect);

endmodule

`default_nettype wire

// ==== rtl/specialRegs.sv ====
// Dedicated datapath registers
`default_nettype none

module specialRegs import datapathPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] bus,
    input  zWord                 aluResult,
    input  logic                 pcIn,
    input  logic                 incPc,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 finished,
    input  logic                 marIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    output logic [dataWidth-1:0] pcData,
    output logic [dataWidth-1:0] irData,
    output logic [dataWidth-1:0] yData,
    output zWord                 zData,
    output logic [dataWidth-1:0] marData,
    output logic [dataWidth-1:0] hiData,
    output logic [dataWidth-1:0] loData
);

    logic finishedQ;    // finished one edge back, for rise detection
    logic zInQ;         // zIn as seen on the edge where finished rose
    logic zLoad;

    // aluResult holds steady while finished is high, so Z takes it
    // the edge after the rise, gated by zIn from the rising edge itself
    assign zLoad = finished && !finishedQ && zInQ;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            finishedQ <= 1'b0;
            zInQ      <= 1'b0;
            pcData    <= '0;
            irData    <= '0;
            yData     <= '0;
            zData     <= '0;
            marData   <= '0;
            hiData    <= '0;
            loData    <= '0;
        end else begin
            finishedQ <= finished;
            zInQ      <= zIn;
            if (pcIn) begin
                pcData <= bus;
            end else if (incPc) begin
                pcData <= pcData + dataWidth'(1);   // load beats increment
            end
            if (irIn)  irData  <= bus;
            if (yIn)   yData   <= bus;
            if (marIn) marData <= bus;
            if (hiIn)  hiData  <= bus;
            if (loIn)  loData  <= bus;
            if (zLoad) zData   <= aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== test/dataPathStimulus.txt ====
# columns: op r2 r3 expectedLo expectedHi, all values in hex
# neg and not act on r3; div gives the quotient in LO and the remainder in HI
and  00000014 00000012 00000010 00000000
or   00000014 00000012 00000016 00000000
add  00000014 00000012 00000026 00000000
sub  00000014 00000012 00000002 00000000
sub  00000012 00000014 fffffffe 00000000
add  ffffffff 00000001 00000000 00000000
and  f0f0a5a5 0ff05a5a 00f00000 00000000
or   f0f0a5a5 0ff05a5a fff0ffff 00000000
neg  00000000 00000005 fffffffb 00000000
not  00000000 0000ffff ffff0000 00000000
neg  12345678 80000000 80000000 00000000
shl  00000001 00000004 00000010 00000000
shl  80000001 00000001 00000002 00000000
shl  0000000f 00000023 00000078 00000000
shr  80000000 0000001f 00000001 00000000
shr  f0000000 00000004 0f000000 00000000
rotl 80000001 00000001 00000003 00000000
rotl 12345678 00000008 34567812 00000000
rotr 00000001 00000001 80000000 00000000
rotr 12345678 00000004 81234567 00000000
mul  00000003 00000004 0000000c 00000000
mul  ffffffff ffffffff 00000001 fffffffe
mul  00010000 00010000 00000000 00000001
mul  0000ffff 0000ffff fffe0001 00000000
div  00000064 00000007 0000000e 00000002
div  00000007 00000064 00000000 00000007
div  ffffffff 00000010 0fffffff 0000000f
div  12345678 00000000 ffffffff 12345678

// ==== test/dataPathTb.sv ====
// Datapath testbench
`default_nettype none

module dataPathTb import datapathPkg::*; ();

    localparam int dataWidth = 32;
    localparam int regCount = 16;
    localparam int clockPeriod = 8;
    localparam int settleTime = 2;        // sample point inside the low phase
    localparam int cyclesPerLine = 60;
    localparam int handshakeLimit = 100;

    logic Clock, rstN;
    logic rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut;
    logic rfIn, pcIn, incPc, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn;
    logic [regIndexWidth-1:0] rfSelect;
    logic [opWidth-1:0]       opSelect;
    logic                     start, read;
    logic [dataWidth-1:0]     memDataIn;
    logic                     finished;
    logic [dataWidth-1:0]     busValue;

    logic [opWidth-1:0]   opQ[$];
    logic [dataWidth-1:0] r2Q[$], r3Q[$], loQ[$], hiQ[$];
    int                   watchdogCycles = 0;
    bit                   watchdogArmed = 0;

    dataPath #(.dataWidth(dataWidth), .regCount(regCount)) dut0 (
        .Clock(Clock), .rstN(rstN),
        .rfOut(rfOut), .pcOut(pcOut), .irOut(irOut), .yOut(yOut), .zLoOut(zLoOut),
        .zHiOut(zHiOut), .marOut(marOut), .hiOut(hiOut), .loOut(loOut), .mdrOut(mdrOut),
        .rfIn(rfIn), .pcIn(pcIn), .incPc(incPc), .irIn(irIn), .yIn(yIn), .zIn(zIn),
        .marIn(marIn), .hiIn(hiIn), .loIn(loIn), .mdrIn(mdrIn),
        .rfSelect(rfSelect), .opSelect(opSelect), .start(start), .read(read),
        .memDataIn(memDataIn), .finished(finished), .busValue(busValue)
    );

    initial begin
        Clock = 1'b0;
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    function automatic bit decodeOpName(input logic [63:0] nm, output logic [opWidth-1:0] op);
        decodeOpName = 1'b1;
        op = opAdd;
        case (nm)
            "add":   op = opAdd;
            "sub":   op = opSub;
            "and":   op = opAnd;
            "or":    op = opOr;
            "shl":   op = opShl;
            "shr":   op = opShr;
            "rotl":  op = opRotl;
            "rotr":  op = opRotr;
            "neg":   op = opNeg;
            "not":   op = opNot;
            "mul":   op = opMul;
            "div":   op = opDiv;
            default: decodeOpName = 1'b0;
        endcase
    endfunction

    function automatic string opLabel(input logic [opWidth-1:0] op);
        string names[12] = '{"add", "sub", "and", "or", "shl", "shr", "rotl", "rotr",
                             "neg", "not", "mul", "div"};
        opLabel = (int'(op) < 12) ? names[op] : "unknown";
    endfunction

    task automatic failRun(input string msg);
        $display("%0s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual);
        if (actual !== expected)
            failRun($sformatf("** Error %0s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            failRun($sformatf("** Error %0s: expected %b, actual %b", name, expected, actual));
    endtask

    // divide is checked as a remainder/quotient pair, everything else as a product
    task automatic checkZ(input string name, input logic [opWidth-1:0] op,
                          input zWord expected, input zWord actual);
        if (op == opDiv) begin
            if (actual.divPair !== expected.divPair)
                failRun($sformatf("** Error %0s: expected rem %h quo %h, actual rem %h quo %h",
                    name, expected.divPair.remainder, expected.divPair.quotient,
                    actual.divPair.remainder, actual.divPair.quotient));
        end else if (actual.product !== expected.product) begin
            failRun($sformatf("** Error %0s: expected %h, actual %h",
                name, expected.product, actual.product));
        end
    endtask

    task automatic sampleBus(output logic [dataWidth-1:0] value);
        #(settleTime);
        value = busValue;
        @(negedge Clock);
    endtask

    task automatic loadReg(input logic [regIndexWidth-1:0] idx, input logic [dataWidth-1:0] value);
        memDataIn = value;
        read = 1'b1;
        mdrIn = 1'b1;                 // memory word into the MDR
        @(negedge Clock);
        read = 1'b0;
        mdrIn = 1'b0;
        mdrOut = 1'b1;
        rfSelect = idx;
        rfIn = 1'b1;
        @(negedge Clock);
        mdrOut = 1'b0;
        rfIn = 1'b0;
    endtask

    task automatic waitFinished(input logic level, input string name);
        int waited;
        waited = 0;
        while (finished !== level) begin
            @(negedge Clock);
            waited++;
            if (waited > handshakeLimit)
                failRun($sformatf("%0s: finished never went to %b", name, level));
        end
    endtask

    // four-phase handshake with R3 on the bus as operand B
    task automatic runOp(input logic [opWidth-1:0] op, input string name);
        checkFlag({name, " finished before start"}, 1'b0, finished);
        rfSelect = 4'd3;
        rfOut = 1'b1;
        opSelect = op;
        zIn = 1'b1;
        start = 1'b1;
        @(negedge Clock);
        waitFinished(1'b1, name);
        rfOut = 1'b0;
        zIn = 1'b0;
        @(negedge Clock);
        checkFlag({name, " finished held"}, 1'b1, finished);  // start still high
        start = 1'b0;
        waitFinished(1'b0, name);
    endtask

    initial begin
        wait (watchdogArmed);
        repeat (watchdogCycles) @(posedge Clock);
        $display("watchdog: tests did not complete within %0d cycles", watchdogCycles);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        int fd;
        int fields;
        string line;
        logic [63:0] opName;
        logic [dataWidth-1:0] r2, r3, lo, hi, loVal, hiVal, val, pcBefore, pcAfter, lastLo;
        logic [opWidth-1:0] op;
        logic [regIndexWidth-1:0] target;
        zWord expZ, actZ;
        string name;

        void'($urandom(72246));
        {rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut} = '0;
        {rfIn, pcIn, incPc, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn} = '0;
        rfSelect = '0;
        opSelect = opAdd;
        start = 1'b0;
        read = 1'b0;
        memDataIn = '0;
        rstN = 1'b0;
        lastLo = '0;

        fd = $fopen("test/dataPathStimulus.txt", "r");
        if (fd == 0) failRun("cannot open test/dataPathStimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 3 || line[0] == "#") continue;   // blank or column notes
            fields = $sscanf(line, "%s %h %h %h %h", opName, r2, r3, lo, hi);
            if (fields != 5) failRun({"malformed stimulus line: ", line});
            if (!decodeOpName(opName, op)) failRun({"unknown operation in line: ", line});
            opQ.push_back(op);
            r2Q.push_back(r2);
            r3Q.push_back(r3);
            loQ.push_back(lo);
            hiQ.push_back(hi);
        end
        $fclose(fd);
        watchdogCycles = (opQ.size() + 2) * cyclesPerLine;  // extra for reset and register path
        watchdogArmed = 1'b1;

        repeat (2) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        checkFlag("finished after reset", 1'b0, finished);

        foreach (opQ[i]) begin
            name = $sformatf("test %0d %0s", i, opLabel(opQ[i]));
            loadReg(4'd2, r2Q[i]);
            loadReg(4'd3, r3Q[i]);
            rfSelect = 4'd2;
            rfOut = 1'b1;
            yIn = 1'b1;               // R2 becomes operand A
            @(negedge Clock);
            rfOut = 1'b0;
            yIn = 1'b0;
            runOp(opQ[i], name);
            zLoOut = 1'b1;
            sampleBus(loVal);
            zLoOut = 1'b0;
            zHiOut = 1'b1;
            sampleBus(hiVal);
            zHiOut = 1'b0;
            expZ.product = {hiQ[i], loQ[i]};
            actZ.product = {hiVal, loVal};
            checkZ({name, " Z"}, opQ[i], expZ, actZ);
            lastLo = loQ[i];
        end

        // copy Z low into a random register and read it back
        target = regIndexWidth'($urandom % regCount);
        zLoOut = 1'b1;
        rfSelect = target;
        rfIn = 1'b1;
        @(negedge Clock);
        zLoOut = 1'b0;
        rfIn = 1'b0;
        rfOut = 1'b1;
        sampleBus(val);
        rfOut = 1'b0;
        checkWord($sformatf("copy of Z low to R%0d", target), lastLo, val);

        pcOut = 1'b1;
        sampleBus(pcBefore);
        pcOut = 1'b0;
        checkWord("PC after reset", '0, pcBefore);
        repeat (3) begin
            incPc = 1'b1;
            @(negedge Clock);
            incPc = 1'b0;
            pcOut = 1'b1;
            sampleBus(pcAfter);
            pcOut = 1'b0;
            checkWord("PC increment", pcBefore + 1, pcAfter);
            pcBefore = pcBefore + 1;
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
